// ==== Makefile ====
TOP = decodeStage_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f \
		--Mdir obj_dir -o simv

run: compile
	./obj_dir/simv > sim.log 2>&1; cat sim.log
	@grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== source/aluDecoder.sv ====
`timescale 1ns/1ps

module aluDecoder import decodePkg::*; (
	input  instrT   instr,
	output aluOpT   aluOp,
	output aluASelT aluASel,
	output aluBSelT aluBSel,
	output extOpT   extOp
);

	always_comb begin
		// Unknown and non-ALU instructions fall back to rs + rt
		aluOp   = aluAdd;
		aluASel = aSelRs;
		aluBSel = bSelRt;
		extOp   = extSign;
		case (opcodeOf(instr))
			opR: begin
				case (funcOf(instr))
					fnAdd, fnAddu: aluOp = aluAdd;
					fnSub, fnSubu: aluOp = aluSub;
					fnAnd: aluOp = aluAnd;
					fnOr: aluOp = aluOr;
					fnXor: aluOp = aluXor;
					fnNor: aluOp = aluNor;
					fnSlt: aluOp = aluSlt;
					fnSltu: aluOp = aluSltu;
					fnSllv: aluOp = aluSll;
					fnSrlv: aluOp = aluSrl;
					fnSrav: aluOp = aluSra;
					// Shift amount comes from the instruction
					fnSll: begin
						aluOp   = aluSll;
						aluASel = aSelShamt;
					end
					fnSrl: begin
						aluOp   = aluSrl;
						aluASel = aSelShamt;
					end
					fnSra: begin
						aluOp   = aluSra;
						aluASel = aSelShamt;
					end
					fnJalr: begin
						aluOp   = aluPassB;
						aluBSel = bSelLinkPc;
					end
					default: ;
				endcase
			end
			opAddi, opAddiu: aluBSel = bSelImm;
			opSlti: begin
				aluOp   = aluSlt;
				aluBSel = bSelImm;
			end
			opSltiu: begin
				aluOp   = aluSltu;
				aluBSel = bSelImm;
			end
			opAndi: begin
				aluOp   = aluAnd;
				aluBSel = bSelImm;
				extOp   = extZero;
			end
			opOri: begin
				aluOp   = aluOr;
				aluBSel = bSelImm;
				extOp   = extZero;
			end
			opXori: begin
				aluOp   = aluXor;
				aluBSel = bSelImm;
				extOp   = extZero;
			end
			opLui: begin
				aluOp   = aluPassB;
				aluBSel = bSelImm;
				extOp   = extUpper;
			end
			// Address is base plus signed offset
			opLb, opLbu, opLh, opLhu, opLw, opSb, opSh, opSw: aluBSel = bSelImm;
			opJal: begin
				aluOp   = aluPassB;
				aluBSel = bSelLinkPc;
			end
			default: ;
		endcase
	end

endmodule

// ==== source/branchDecoder.sv ====
`timescale 1ns/1ps

module branchDecoder import decodePkg::*; (
	input  instrT  instr,
	output npcSelT npcSel,
	output npcOpT  npcOp,
	output cmpOpT  cmpOp
);

	// Load npcSel with npcImm and the compare for a taken-if branch
	always_comb begin
		npcSel = npcSeq;
		npcOp  = npcBranch;
		cmpOp  = cmpEq;
		case (opcodeOf(instr))
			opBeq: npcSel = npcImm;
			opBne: begin
				npcSel = npcImm;
				cmpOp  = cmpNe;
			end
			opBgtz: begin
				npcSel = npcImm;
				cmpOp  = cmpGtz;
			end
			opBlez: begin
				npcSel = npcImm;
				cmpOp  = cmpLez;
			end
			opRegImm: begin
				if (rtOf(instr) == rtBgez) begin
					npcSel = npcImm;
					cmpOp  = cmpGez;
				end else if (rtOf(instr) == rtBltz) begin
					npcSel = npcImm;
					cmpOp  = cmpLtz;
				end
			end
			opJ, opJal: begin
				npcSel = npcImm;
				npcOp  = npcJump;
			end
			opR: begin
				if (funcOf(instr) == fnJr || funcOf(instr) == fnJalr) begin
					npcSel = npcReg;
					npcOp  = npcJump;
				end
			end
			default: ;
		endcase
	end

endmodule

// ==== source/decodePkg.sv ====
package decodePkg;

	//////////////////////////////////////////////////////////////////////
	// Instruction fields
	//////////////////////////////////////////////////////////////////////

	typedef logic [31:0] instrT;
	typedef logic [5:0]  opcodeT;
	typedef logic [5:0]  funcT;
	typedef logic [4:0]  regIdxT;

	// Tnew or Tuse in stages, 3 means never
	typedef logic [1:0] stageTimeT;

	localparam stageTimeT tNever = 2'd3;
	localparam regIdxT linkReg = 5'd31;

	// Primary opcodes
	localparam opcodeT opR      = 6'b000000;
	localparam opcodeT opRegImm = 6'b000001;
	localparam opcodeT opJ      = 6'b000010;
	localparam opcodeT opJal    = 6'b000011;
	localparam opcodeT opBeq    = 6'b000100;
	localparam opcodeT opBne    = 6'b000101;
	localparam opcodeT opBlez   = 6'b000110;
	localparam opcodeT opBgtz   = 6'b000111;
	localparam opcodeT opAddi   = 6'b001000;
	localparam opcodeT opAddiu  = 6'b001001;
	localparam opcodeT opSlti   = 6'b001010;
	localparam opcodeT opSltiu  = 6'b001011;
	localparam opcodeT opAndi   = 6'b001100;
	localparam opcodeT opOri    = 6'b001101;
	localparam opcodeT opXori   = 6'b001110;
	localparam opcodeT opLui    = 6'b001111;
	localparam opcodeT opLb     = 6'b100000;
	localparam opcodeT opLh     = 6'b100001;
	localparam opcodeT opLw     = 6'b100011;
	localparam opcodeT opLbu    = 6'b100100;
	localparam opcodeT opLhu    = 6'b100101;
	localparam opcodeT opSb     = 6'b101000;
	localparam opcodeT opSh     = 6'b101001;
	localparam opcodeT opSw     = 6'b101011;

	// R-type function codes
	localparam funcT fnSll  = 6'b000000;
	localparam funcT fnSrl  = 6'b000010;
	localparam funcT fnSra  = 6'b000011;
	localparam funcT fnSllv = 6'b000100;
	localparam funcT fnSrlv = 6'b000110;
	localparam funcT fnSrav = 6'b000111;
	localparam funcT fnJr   = 6'b001000;
	localparam funcT fnJalr = 6'b001001;
	localparam funcT fnAdd  = 6'b100000;
	localparam funcT fnAddu = 6'b100001;
	localparam funcT fnSub  = 6'b100010;
	localparam funcT fnSubu = 6'b100011;
	localparam funcT fnAnd  = 6'b100100;
	localparam funcT fnOr   = 6'b100101;
	localparam funcT fnXor  = 6'b100110;
	localparam funcT fnNor  = 6'b100111;
	localparam funcT fnSlt  = 6'b101010;
	localparam funcT fnSltu = 6'b101011;

	// Selected by rt under opRegImm
	localparam regIdxT rtBltz = 5'b00000;
	localparam regIdxT rtBgez = 5'b00001;

	//////////////////////////////////////////////////////////////////////
	// Control field encodings
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		aluAdd   = 4'd0,
		aluSub   = 4'd1,
		aluAnd   = 4'd2,
		aluOr    = 4'd3,
		aluSrl   = 4'd4,
		aluSra   = 4'd5,
		aluSll   = 4'd6,
		aluSlt   = 4'd7,
		aluSltu  = 4'd8,
		aluNor   = 4'd9,
		aluXor   = 4'd10,
		aluPassB = 4'd12
	} aluOpT;

	typedef enum logic [1:0] {aSelRs = 2'd0, aSelShamt = 2'd1} aluASelT;
	typedef enum logic [1:0] {bSelRt = 2'd0, bSelImm = 2'd1, bSelLinkPc = 2'd2} aluBSelT;
	typedef enum logic [1:0] {extSign = 2'd0, extZero = 2'd1, extUpper = 2'd2} extOpT;

	typedef enum logic [2:0] {
		ldWord  = 3'd0,
		ldByteU = 3'd1,
		ldByteS = 3'd2,
		ldHalfU = 3'd3,
		ldHalfS = 3'd4
	} loadKindT;

	typedef enum logic [1:0] {stWord = 2'd0, stByte = 2'd1, stHalf = 2'd2} storeKindT;

	typedef enum logic [1:0] {npcSeq = 2'd0, npcImm = 2'd1, npcReg = 2'd2} npcSelT;
	typedef enum logic {npcBranch = 1'b0, npcJump = 1'b1} npcOpT;

	typedef enum logic [2:0] {
		cmpEq  = 3'd0,
		cmpGez = 3'd1,
		cmpGtz = 3'd2,
		cmpLez = 3'd3,
		cmpLtz = 3'd4,
		cmpNe  = 3'd5
	} cmpOpT;

	typedef enum logic [1:0] {destRd = 2'd0, destRt = 2'd1, destLink = 2'd3} destSelT;
	typedef enum logic {wdAlu = 1'b0, wdMem = 1'b1} wdSelT;

	//////////////////////////////////////////////////////////////////////
	// Field extraction
	//////////////////////////////////////////////////////////////////////

	function automatic opcodeT opcodeOf(instrT i);
		return i[31:26];
	endfunction

	function automatic funcT funcOf(instrT i);
		return i[5:0];
	endfunction

	function automatic regIdxT rsOf(instrT i);
		return i[25:21];
	endfunction

	function automatic regIdxT rtOf(instrT i);
		return i[20:16];
	endfunction

	function automatic regIdxT rdOf(instrT i);
		return i[15:11];
	endfunction

endpackage

// ==== source/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage import decodePkg::*; (
	input  logic      clk,
	input  logic      arstN,
	input  logic      instrValid,
	input  instrT     instr,
	output logic      instrReady,
	output logic      ctrlValid,
	output aluOpT     aluOp,
	output aluASelT   aluASel,
	output aluBSelT   aluBSel,
	output extOpT     extOp,
	output logic      memRead,
	output logic      memWrite,
	output loadKindT  loadKind,
	output storeKindT storeKind,
	output npcSelT    npcSel,
	output npcOpT     npcOp,
	output cmpOpT     cmpOp,
	output logic      regWrite,
	output regIdxT    destReg,
	output wdSelT     wdSel
);

	aluOpT decAluOp;
	aluASelT decAluASel;
	aluBSelT decAluBSel;
	extOpT decExtOp;
	logic decMemRead;
	logic decMemWrite;
	loadKindT decLoadKind;
	storeKindT decStoreKind;
	npcSelT decNpcSel;
	npcOpT decNpcOp;
	cmpOpT decCmpOp;
	logic decRegWrite;
	regIdxT decDestReg;
	wdSelT decWdSel;
	stageTimeT decTNew;
	stageTimeT decTUseRs;
	stageTimeT decTUseRt;

	logic issue;
	logic eValid;
	regIdxT eDest;
	stageTimeT eTNew;
	logic mValid;
	regIdxT mDest;
	stageTimeT mTNew;

	//////////////////////////////////////////////////////////////////////
	// Combinational decode
	//////////////////////////////////////////////////////////////////////

	aluDecoder i_aluDecoder (
		.instr   (instr),
		.aluOp   (decAluOp),
		.aluASel (decAluASel),
		.aluBSel (decAluBSel),
		.extOp   (decExtOp)
	);

	memDecoder i_memDecoder (
		.instr     (instr),
		.memRead   (decMemRead),
		.memWrite  (decMemWrite),
		.loadKind  (decLoadKind),
		.storeKind (decStoreKind)
	);

	branchDecoder i_branchDecoder (
		.instr  (instr),
		.npcSel (decNpcSel),
		.npcOp  (decNpcOp),
		.cmpOp  (decCmpOp)
	);

	hazardTiming i_hazardTiming (
		.instr    (instr),
		.regWrite (decRegWrite),
		.destReg  (decDestReg),
		.wdSel    (decWdSel),
		.tNew     (decTNew),
		.tUseRs   (decTUseRs),
		.tUseRt   (decTUseRt)
	);

	//////////////////////////////////////////////////////////////////////
	// Producers in flight and issue control
	//////////////////////////////////////////////////////////////////////

	producerTrack i_producerTrack (
		.clk        (clk),
		.arstN      (arstN),
		.issue      (issue),
		.issueWrite (decRegWrite),
		.issueDest  (decDestReg),
		.issueTNew  (decTNew),
		.eValid     (eValid),
		.eDest      (eDest),
		.eTNew      (eTNew),
		.mValid     (mValid),
		.mDest      (mDest),
		.mTNew      (mTNew)
	);

	stallControl i_stallControl (
		.clk          (clk),
		.arstN        (arstN),
		.instrValid   (instrValid),
		.instr        (instr),
		.decAluOp     (decAluOp),
		.decAluASel   (decAluASel),
		.decAluBSel   (decAluBSel),
		.decExtOp     (decExtOp),
		.decMemRead   (decMemRead),
		.decMemWrite  (decMemWrite),
		.decLoadKind  (decLoadKind),
		.decStoreKind (decStoreKind),
		.decNpcSel    (decNpcSel),
		.decNpcOp     (decNpcOp),
		.decCmpOp     (decCmpOp),
		.decRegWrite  (decRegWrite),
		.decDestReg   (decDestReg),
		.decWdSel     (decWdSel),
		.tUseRs       (decTUseRs),
		.tUseRt       (decTUseRt),
		.eValid       (eValid),
		.eDest        (eDest),
		.eTNew        (eTNew),
		.mValid       (mValid),
		.mDest        (mDest),
		.mTNew        (mTNew),
		.instrReady   (instrReady),
		.issue        (issue),
		.ctrlValid    (ctrlValid),
		.aluOp        (aluOp),
		.aluASel      (aluASel),
		.aluBSel      (aluBSel),
		.extOp        (extOp),
		.memRead      (memRead),
		.memWrite     (memWrite),
		.loadKind     (loadKind),
		.storeKind    (storeKind),
		.npcSel       (npcSel),
		.npcOp        (npcOp),
		.cmpOp        (cmpOp),
		.regWrite     (regWrite),
		.destReg      (destReg),
		.wdSel        (wdSel)
	);

endmodule

// ==== source/hazardTiming.sv ====
`timescale 1ns/1ps

module hazardTiming import decodePkg::*; (
	input  instrT     instr,
	output logic      regWrite,
	output regIdxT    destReg,
	output wdSelT     wdSel,
	output stageTimeT tNew,
	output stageTimeT tUseRs,
	output stageTimeT tUseRt
);

	destSelT destSel;
	logic writes;

	always_comb begin
		writes  = 1'b0;
		destSel = destRd;
		wdSel   = wdAlu;
		tNew    = 2'd0;
		tUseRs  = tNever;
		tUseRt  = tNever;
		case (opcodeOf(instr))
			opR: begin
				case (funcOf(instr))
					fnAdd, fnAddu, fnSub, fnSubu, fnSlt, fnSltu, fnAnd, fnOr, fnXor, fnNor,
					fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav: begin
						writes = 1'b1;
						tNew   = 2'd1;
						tUseRs = 2'd1;
						tUseRt = 2'd1;
					end
					fnJr: tUseRs = 2'd0;
					// Link value is ready at issue
					fnJalr: begin
						writes = 1'b1;
						tUseRs = 2'd0;
					end
					default: ;
				endcase
			end
			opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
				writes  = 1'b1;
				destSel = destRt;
				tNew    = 2'd1;
				tUseRs  = 2'd1;
			end
			opLb, opLbu, opLh, opLhu, opLw: begin
				writes  = 1'b1;
				destSel = destRt;
				wdSel   = wdMem;
				tNew    = 2'd2;
				tUseRs  = 2'd1;
			end
			opSb, opSh, opSw: begin
				tUseRs = 2'd1;
				tUseRt = 2'd1;
			end
			// Branches compare in decode
			opBeq, opBne, opBgtz, opBlez: begin
				tUseRs = 2'd0;
				tUseRt = 2'd0;
			end
			opRegImm: begin
				if (rtOf(instr) == rtBgez || rtOf(instr) == rtBltz)
					tUseRs = 2'd0;
			end
			opJal: begin
				writes  = 1'b1;
				destSel = destLink;
			end
			default: ;
		endcase
	end

	always_comb begin
		case (destSel)
			destRt: destReg = rtOf(instr);
			destLink: destReg = linkReg;
			default: destReg = rdOf(instr);
		endcase
	end

	// Register 0 is never a real producer
	assign regWrite = writes && (destReg != '0);

endmodule

// ==== source/memDecoder.sv ====
`timescale 1ns/1ps

module memDecoder import decodePkg::*; (
	input  instrT     instr,
	output logic      memRead,
	output logic      memWrite,
	output loadKindT  loadKind,
	output storeKindT storeKind
);

	always_comb begin
		memRead   = 1'b0;
		memWrite  = 1'b0;
		loadKind  = ldWord;
		storeKind = stWord;
		case (opcodeOf(instr))
			opLw: memRead = 1'b1;
			opLb: begin
				memRead  = 1'b1;
				loadKind = ldByteS;
			end
			opLbu: begin
				memRead  = 1'b1;
				loadKind = ldByteU;
			end
			opLh: begin
				memRead  = 1'b1;
				loadKind = ldHalfS;
			end
			opLhu: begin
				memRead  = 1'b1;
				loadKind = ldHalfU;
			end
			opSw: memWrite = 1'b1;
			// Partial stores read the word back to merge into it
			opSb: begin
				memRead   = 1'b1;
				memWrite  = 1'b1;
				storeKind = stByte;
			end
			opSh: begin
				memRead   = 1'b1;
				memWrite  = 1'b1;
				storeKind = stHalf;
			end
			default: ;
		endcase
	end

endmodule

// ==== source/producerTrack.sv ====
`timescale 1ns/1ps

module producerTrack import decodePkg::*; (
	input  logic      clk,
	input  logic      arstN,
	input  logic      issue,
	input  logic      issueWrite,
	input  regIdxT    issueDest,
	input  stageTimeT issueTNew,
	output logic      eValid,
	output regIdxT    eDest,
	output stageTimeT eTNew,
	output logic      mValid,
	output regIdxT    mDest,
	output stageTimeT mTNew
);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			eValid <= 1'b0;
			mValid <= 1'b0;
		end else begin
			// Stall cycles push a bubble into E
			eValid <= issue && issueWrite;
			mValid <= eValid;
		end
	end

	always_ff @(posedge clk) begin
		eDest <= issueDest;
		eTNew <= issueTNew;
		mDest <= eDest;
		// One stage closer to the result, floor at 0
		mTNew <= (eTNew == 2'd0) ? 2'd0 : eTNew - 2'd1;
	end

endmodule

// ==== source/stallControl.sv ====
`timescale 1ns/1ps

module stallControl import decodePkg::*; (
	input  logic      clk,
	input  logic      arstN,
	input  logic      instrValid,
	input  instrT     instr,
	input  aluOpT     decAluOp,
	input  aluASelT   decAluASel,
	input  aluBSelT   decAluBSel,
	input  extOpT     decExtOp,
	input  logic      decMemRead,
	input  logic      decMemWrite,
	input  loadKindT  decLoadKind,
	input  storeKindT decStoreKind,
	input  npcSelT    decNpcSel,
	input  npcOpT     decNpcOp,
	input  cmpOpT     decCmpOp,
	input  logic      decRegWrite,
	input  regIdxT    decDestReg,
	input  wdSelT     decWdSel,
	input  stageTimeT tUseRs,
	input  stageTimeT tUseRt,
	input  logic      eValid,
	input  regIdxT    eDest,
	input  stageTimeT eTNew,
	input  logic      mValid,
	input  regIdxT    mDest,
	input  stageTimeT mTNew,
	output logic      instrReady,
	output logic      issue,
	output logic      ctrlValid,
	output aluOpT     aluOp,
	output aluASelT   aluASel,
	output aluBSelT   aluBSel,
	output extOpT     extOp,
	output logic      memRead,
	output logic      memWrite,
	output loadKindT  loadKind,
	output storeKindT storeKind,
	output npcSelT    npcSel,
	output npcOpT     npcOp,
	output cmpOpT     cmpOp,
	output logic      regWrite,
	output regIdxT    destReg,
	output wdSelT     wdSel
);

	logic hazard;

	// Source must wait while a producer still needs more stages than it has
	function automatic logic srcStall(
		regIdxT src, stageTimeT tUse,
		logic eV, regIdxT eD, stageTimeT eT,
		logic mV, regIdxT mD, stageTimeT mT
	);
		logic eHit;
		logic mHit;
		eHit = eV && (eD == src) && (eT > tUse);
		mHit = mV && (mD == src) && (mT > tUse);
		return (src != '0) && (tUse != tNever) && (eHit || mHit);
	endfunction

	always_comb begin
		hazard = srcStall(rsOf(instr), tUseRs, eValid, eDest, eTNew, mValid, mDest, mTNew)
			|| srcStall(rtOf(instr), tUseRt, eValid, eDest, eTNew, mValid, mDest, mTNew);
	end

	assign instrReady = !hazard;
	assign issue = instrValid && instrReady;

	//////////////////////////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ctrlValid <= 1'b0;
			regWrite  <= 1'b0;
			memRead   <= 1'b0;
			memWrite  <= 1'b0;
			npcSel    <= npcSeq;
		end else begin
			ctrlValid <= issue;
			regWrite  <= issue && decRegWrite;
			memRead   <= issue && decMemRead;
			memWrite  <= issue && decMemWrite;
			npcSel    <= issue ? decNpcSel : npcSeq;
		end
	end

	// Only meaningful while ctrlValid is high
	always_ff @(posedge clk) begin
		if (issue) begin
			aluOp     <= decAluOp;
			aluASel   <= decAluASel;
			aluBSel   <= decAluBSel;
			extOp     <= decExtOp;
			loadKind  <= decLoadKind;
			storeKind <= decStoreKind;
			npcOp     <= decNpcOp;
			cmpOp     <= decCmpOp;
			destReg   <= decDestReg;
			wdSel     <= decWdSel;
		end
	end

endmodule

// ==== tb.f ====
source/decodePkg.sv
source/aluDecoder.sv
source/memDecoder.sv
source/branchDecoder.sv
source/hazardTiming.sv
source/producerTrack.sv
source/stallControl.sv
source/decodeStage.sv
verif/decodeStage_checker.sv
verif/decodeStage_tb.sv

// ==== verif/decodeStage_checker.sv ====
`timescale 1ns/1ps

module decodeStage_checker (
	input logic clk,
	input logic arstN,
	input logic instrValid,
	input logic instrReady,
	input logic ctrlValid,
	input logic memRead,
	input logic memWrite,
	input logic regWrite
);

	// Bubbles have no side effects
	quietBubble: assert property (@(posedge clk) disable iff (!arstN)
		!ctrlValid |-> !(memRead || memWrite || regWrite))
		else $error("regWrite or memory access while ctrlValid is low");

	// Held instruction must not reach the output
	stallBubble: assert property (@(posedge clk) disable iff (!arstN)
		(instrValid && !instrReady) |=> !ctrlValid)
		else $error("ctrlValid high after a stalled cycle");

	readyAfterReset: assert property (@(posedge clk)
		$rose(arstN) |-> instrReady)
		else $error("instrReady low in the first cycle after reset");

endmodule

bind decodeStage decodeStage_checker i_checker (
	.clk        (clk),
	.arstN      (arstN),
	.instrValid (instrValid),
	.instrReady (instrReady),
	.ctrlValid  (ctrlValid),
	.memRead    (memRead),
	.memWrite   (memWrite),
	.regWrite   (regWrite)
);

// ==== verif/decodeStage_tb.sv ====
`timescale 1ns/1ps

module decodeStage_tb import decodePkg::*; ();

	typedef struct {
		string     name;
		instrT     word;
		aluOpT     aluOp;
		aluASelT   aluASel;
		aluBSelT   aluBSel;
		extOpT     extOp;
		logic      memRead;
		logic      memWrite;
		loadKindT  loadKind;
		storeKindT storeKind;
		npcSelT    npcSel;
		npcOpT     npcOp;
		cmpOpT     cmpOp;
		logic      regWrite;
		regIdxT    destReg;
		wdSelT     wdSel;
		int        stalls;
	} vectorT;

	logic      clk = 1'b0;
	logic      arstN;
	logic      instrValid;
	instrT     instr;
	logic      instrReady;
	logic      ctrlValid;
	aluOpT     aluOp;
	aluASelT   aluASel;
	aluBSelT   aluBSel;
	extOpT     extOp;
	logic      memRead;
	logic      memWrite;
	loadKindT  loadKind;
	storeKindT storeKind;
	npcSelT    npcSel;
	npcOpT     npcOp;
	cmpOpT     cmpOp;
	logic      regWrite;
	regIdxT    destReg;
	wdSelT     wdSel;

	vectorT vectors[$];
	int     errors = 0;
	int     badTests = 0;
	int     testCount = 0;
	bit     testBad;
	int     cycles = 0;
	int     cycleLimit = 1000;

	decodeStage i_dut (
		.clk        (clk),
		.arstN      (arstN),
		.instrValid (instrValid),
		.instr      (instr),
		.instrReady (instrReady),
		.ctrlValid  (ctrlValid),
		.aluOp      (aluOp),
		.aluASel    (aluASel),
		.aluBSel    (aluBSel),
		.extOp      (extOp),
		.memRead    (memRead),
		.memWrite   (memWrite),
		.loadKind   (loadKind),
		.storeKind  (storeKind),
		.npcSel     (npcSel),
		.npcOp      (npcOp),
		.cmpOp      (cmpOp),
		.regWrite   (regWrite),
		.destReg    (destReg),
		.wdSel      (wdSel)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", cycleLimit);
			$display("sim failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Instruction encoding
	//////////////////////////////////////////////////////////////////////

	function automatic instrT rType(regIdxT rs, regIdxT rt, regIdxT rd, logic [4:0] sh,
			funcT fn);
		return {opR, rs, rt, rd, sh, fn};
	endfunction

	function automatic instrT iType(opcodeT op, regIdxT rs, regIdxT rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic instrT jType(opcodeT op, logic [25:0] target);
		return {op, target};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic reportMismatch(input string sig, input string expStr, input string actStr);
		$display("mismatch at %0t: %s expected %s, got %s", $time, sig, expStr, actStr);
		errors++;
		testBad = 1'b1;
	endtask

	task automatic checkBit(input string sig, input logic exp, input logic act);
		if (act !== exp)
			reportMismatch(sig, $sformatf("%b", exp), $sformatf("%b", act));
	endtask

	task automatic checkReg(input string sig, input regIdxT exp, input regIdxT act);
		if (act !== exp)
			reportMismatch(sig, $sformatf("%0d", exp), $sformatf("%0d", act));
	endtask

	task automatic checkAluOp(input string sig, input aluOpT exp, input aluOpT act);
		if (act !== exp)
			reportMismatch(sig, exp.name(), act.name());
	endtask

	task automatic checkASel(input string sig, input aluASelT exp, input aluASelT act);
		if (act !== exp)
			reportMismatch(sig, exp.name(), act.name());
	endtask

	task automatic checkBSel(input string sig, input aluBSelT exp, input aluBSelT act);
		if (act !== exp)
			reportMismatch(sig, exp.name(), act.name());
	endtask

	task automatic checkExt(input string sig, input extOpT exp, input extOpT act);
		if (act !== exp)
			reportMismatch(sig, exp.name(), act.name());
	endtask

	task automatic checkLoadKind(input string sig, input loadKindT exp, input loadKindT act);
		if (act !== exp)
			reportMismatch(sig, exp.name(), act.name());
	endtask

	task automatic checkStoreKind(input string sig, input storeKindT exp, input storeKindT act);
		if (act !== exp)
			reportMismatch(sig, exp.name(), act.name());
	endtask

	task automatic checkNpcSel(input string sig, input npcSelT exp, input npcSelT act);
		if (act !== exp)
			reportMismatch(sig, exp.name(), act.name());
	endtask

	task automatic checkNpcOp(input string sig, input npcOpT exp, input npcOpT act);
		if (act !== exp)
			reportMismatch(sig, exp.name(), act.name());
	endtask

	task automatic checkCmpOp(input string sig, input cmpOpT exp, input cmpOpT act);
		if (act !== exp)
			reportMismatch(sig, exp.name(), act.name());
	endtask

	task automatic checkWdSel(input string sig, input wdSelT exp, input wdSelT act);
		if (act !== exp)
			reportMismatch(sig, exp.name(), act.name());
	endtask

	task automatic checkResult(input vectorT v);
		checkBit("ctrlValid", 1'b1, ctrlValid);
		checkAluOp("aluOp", v.aluOp, aluOp);
		checkASel("aluASel", v.aluASel, aluASel);
		checkBSel("aluBSel", v.aluBSel, aluBSel);
		checkExt("extOp", v.extOp, extOp);
		checkBit("memRead", v.memRead, memRead);
		checkBit("memWrite", v.memWrite, memWrite);
		checkLoadKind("loadKind", v.loadKind, loadKind);
		checkStoreKind("storeKind", v.storeKind, storeKind);
		checkNpcSel("npcSel", v.npcSel, npcSel);
		checkNpcOp("npcOp", v.npcOp, npcOp);
		checkCmpOp("cmpOp", v.cmpOp, cmpOp);
		checkBit("regWrite", v.regWrite, regWrite);
		checkWdSel("wdSel", v.wdSel, wdSel);
		// Destination is don't care without a write
		if (v.regWrite)
			checkReg("destReg", v.destReg, destReg);
	endtask

	task automatic checkIdle();
		checkBit("ctrlValid", 1'b0, ctrlValid);
		checkBit("instrReady", 1'b1, instrReady);
		checkBit("regWrite", 1'b0, regWrite);
		checkBit("memRead", 1'b0, memRead);
		checkBit("memWrite", 1'b0, memWrite);
		checkNpcSel("npcSel", npcSeq, npcSel);
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (testBad)
			badTests++;
		$display("test %0d %s: %s", testCount, name, testBad ? "bad" : "ok");
		testBad = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////////////////////////

	task automatic addVector(input string n, input instrT w, input aluOpT op,
			input aluASelT aSel, input aluBSelT bSel, input extOpT ext,
			input logic rd, input logic wr, input loadKindT ld, input storeKindT st,
			input npcSelT nSel, input npcOpT nOp, input cmpOpT cmp,
			input logic rw, input regIdxT dest, input wdSelT wd, input int stalls);
		vectorT v;
		v.name = n;
		v.word = w;
		v.aluOp = op;
		v.aluASel = aSel;
		v.aluBSel = bSel;
		v.extOp = ext;
		v.memRead = rd;
		v.memWrite = wr;
		v.loadKind = ld;
		v.storeKind = st;
		v.npcSel = nSel;
		v.npcOp = nOp;
		v.cmpOp = cmp;
		v.regWrite = rw;
		v.destReg = dest;
		v.wdSel = wd;
		v.stalls = stalls;
		vectors.push_back(v);
	endtask

	// Argument order is alu op, selects, ext, rd, wr, kinds, npc, cmp, write, dest, wdSel, stalls
	task automatic buildVectors();
		addVector("addu", rType(5'd1, 5'd2, 5'd3, 5'd0, fnAddu), aluAdd, aSelRs, bSelRt,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcSeq, npcBranch, cmpEq, 1'b1, 5'd3, wdAlu, 0);
		addVector("subu", rType(5'd4, 5'd5, 5'd6, 5'd0, fnSubu), aluSub, aSelRs, bSelRt,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcSeq, npcBranch, cmpEq, 1'b1, 5'd6, wdAlu, 0);
		addVector("sll", rType(5'd0, 5'd8, 5'd7, 5'd4, fnSll), aluSll, aSelShamt, bSelRt,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcSeq, npcBranch, cmpEq, 1'b1, 5'd7, wdAlu, 0);
		addVector("sra", rType(5'd0, 5'd10, 5'd9, 5'd2, fnSra), aluSra, aSelShamt, bSelRt,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcSeq, npcBranch, cmpEq, 1'b1, 5'd9, wdAlu, 0);
		addVector("srlv", rType(5'd13, 5'd12, 5'd11, 5'd0, fnSrlv), aluSrl, aSelRs, bSelRt,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcSeq, npcBranch, cmpEq, 1'b1, 5'd11, wdAlu, 0);
		addVector("slt", rType(5'd15, 5'd16, 5'd14, 5'd0, fnSlt), aluSlt, aSelRs, bSelRt,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcSeq, npcBranch, cmpEq, 1'b1, 5'd14, wdAlu, 0);
		addVector("nor", rType(5'd18, 5'd19, 5'd17, 5'd0, fnNor), aluNor, aSelRs, bSelRt,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcSeq, npcBranch, cmpEq, 1'b1, 5'd17, wdAlu, 0);
		// Write to register 0 is dropped
		addVector("addu r0", rType(5'd1, 5'd2, 5'd0, 5'd0, fnAddu), aluAdd, aSelRs, bSelRt,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcSeq, npcBranch, cmpEq, 1'b0, 5'd0, wdAlu, 0);
		// Source register 0 never waits on the dropped write
		addVector("addiu r0 src", iType(opAddiu, 5'd0, 5'd20, 16'hfff0), aluAdd, aSelRs, bSelImm,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcSeq, npcBranch, cmpEq, 1'b1, 5'd20, wdAlu, 0);
		addVector("ori", iType(opOri, 5'd23, 5'd22, 16'h00ff), aluOr, aSelRs, bSelImm,
			extZero, 1'b0, 1'b0, ldWord, stWord, npcSeq, npcBranch, cmpEq, 1'b1, 5'd22, wdAlu, 0);
		addVector("lui", iType(opLui, 5'd0, 5'd24, 16'h1234), aluPassB, aSelRs, bSelImm,
			extUpper, 1'b0, 1'b0, ldWord, stWord, npcSeq, npcBranch, cmpEq, 1'b1, 5'd24, wdAlu, 0);
		addVector("slti", iType(opSlti, 5'd26, 5'd25, 16'h0005), aluSlt, aSelRs, bSelImm,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcSeq, npcBranch, cmpEq, 1'b1, 5'd25, wdAlu, 0);
		addVector("lw", iType(opLw, 5'd29, 5'd8, 16'h0004), aluAdd, aSelRs, bSelImm,
			extSign, 1'b1, 1'b0, ldWord, stWord, npcSeq, npcBranch, cmpEq, 1'b1, 5'd8, wdMem, 0);
		// Load result not ready for the next ALU op
		addVector("addu dep", rType(5'd8, 5'd9, 5'd10, 5'd0, fnAddu), aluAdd, aSelRs, bSelRt,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcSeq, npcBranch, cmpEq, 1'b1, 5'd10, wdAlu, 1);
		addVector("beq dep", iType(opBeq, 5'd10, 5'd11, 16'h0010), aluAdd, aSelRs, bSelRt,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcImm, npcBranch, cmpEq, 1'b0, 5'd0, wdAlu, 1);
		addVector("lb", iType(opLb, 5'd2, 5'd12, 16'h0000), aluAdd, aSelRs, bSelImm,
			extSign, 1'b1, 1'b0, ldByteS, stWord, npcSeq, npcBranch, cmpEq, 1'b1, 5'd12, wdMem, 0);
		addVector("lhu", iType(opLhu, 5'd3, 5'd13, 16'h0002), aluAdd, aSelRs, bSelImm,
			extSign, 1'b1, 1'b0, ldHalfU, stWord, npcSeq, npcBranch, cmpEq, 1'b1, 5'd13, wdMem, 0);
		addVector("sb", iType(opSb, 5'd5, 5'd4, 16'h0001), aluAdd, aSelRs, bSelImm,
			extSign, 1'b1, 1'b1, ldWord, stByte, npcSeq, npcBranch, cmpEq, 1'b0, 5'd0, wdAlu, 0);
		addVector("sw", iType(opSw, 5'd7, 5'd6, 16'h0008), aluAdd, aSelRs, bSelImm,
			extSign, 1'b0, 1'b1, ldWord, stWord, npcSeq, npcBranch, cmpEq, 1'b0, 5'd0, wdAlu, 0);
		addVector("bne", iType(opBne, 5'd1, 5'd2, 16'h0004), aluAdd, aSelRs, bSelRt,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcImm, npcBranch, cmpNe, 1'b0, 5'd0, wdAlu, 0);
		addVector("bgez", iType(opRegImm, 5'd3, rtBgez, 16'h0008), aluAdd, aSelRs, bSelRt,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcImm, npcBranch, cmpGez, 1'b0, 5'd0, wdAlu, 0);
		addVector("bltz", iType(opRegImm, 5'd4, rtBltz, 16'hfffc), aluAdd, aSelRs, bSelRt,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcImm, npcBranch, cmpLtz, 1'b0, 5'd0, wdAlu, 0);
		addVector("bgtz", iType(opBgtz, 5'd5, 5'd0, 16'h0002), aluAdd, aSelRs, bSelRt,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcImm, npcBranch, cmpGtz, 1'b0, 5'd0, wdAlu, 0);
		addVector("blez", iType(opBlez, 5'd6, 5'd0, 16'h0002), aluAdd, aSelRs, bSelRt,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcImm, npcBranch, cmpLez, 1'b0, 5'd0, wdAlu, 0);
		addVector("j", jType(opJ, 26'h0000100), aluAdd, aSelRs, bSelRt,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcImm, npcJump, cmpEq, 1'b0, 5'd0, wdAlu, 0);
		addVector("jal", jType(opJal, 26'h0000200), aluPassB, aSelRs, bSelLinkPc,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcImm, npcJump, cmpEq, 1'b1, 5'd31, wdAlu, 0);
		// Link is ready at once, so jr does not wait
		addVector("jr", rType(5'd31, 5'd0, 5'd0, 5'd0, fnJr), aluAdd, aSelRs, bSelRt,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcReg, npcJump, cmpEq, 1'b0, 5'd0, wdAlu, 0);
		addVector("jalr", rType(5'd31, 5'd0, 5'd30, 5'd0, fnJalr), aluPassB, aSelRs, bSelLinkPc,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcReg, npcJump, cmpEq, 1'b1, 5'd30, wdAlu, 0);
		addVector("lw", iType(opLw, 5'd1, 5'd14, 16'h0000), aluAdd, aSelRs, bSelImm,
			extSign, 1'b1, 1'b0, ldWord, stWord, npcSeq, npcBranch, cmpEq, 1'b1, 5'd14, wdMem, 0);
		addVector("unknown", iType(6'b111111, 5'd14, 5'd14, 16'h0000), aluAdd, aSelRs, bSelRt,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcSeq, npcBranch, cmpEq, 1'b0, 5'd0, wdAlu, 0);
		// One instruction between load and use hides the load delay
		addVector("addu gap", rType(5'd14, 5'd1, 5'd15, 5'd0, fnAddu), aluAdd, aSelRs, bSelRt,
			extSign, 1'b0, 1'b0, ldWord, stWord, npcSeq, npcBranch, cmpEq, 1'b1, 5'd15, wdAlu, 0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int waited;
		arstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		testBad = 1'b0;
		buildVectors();
		cycleLimit = 8 + vectors.size() * 4 + 40;

		repeat (8) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		checkIdle();
		finishTest("reset");

		@(posedge clk);
		instrValid <= 1'b1;
		instr <= vectors[0].word;
		@(negedge clk);
		for (int i = 0; i < vectors.size(); i++) begin
			waited = 0;
			while (!instrReady) begin
				waited++;
				@(negedge clk);
				checkBit("ctrlValid", 1'b0, ctrlValid);
			end
			// Next entry goes out on the transfer edge
			@(posedge clk);
			if (i + 1 < vectors.size()) begin
				instr <= vectors[i + 1].word;
			end else begin
				instrValid <= 1'b0;
				instr <= '0;
			end
			@(negedge clk);
			checkResult(vectors[i]);
			if (waited != vectors[i].stalls) begin
				$display("test %0d %s: accepted after %0d stall cycles instead of %0d",
					testCount + 1, vectors[i].name, waited, vectors[i].stalls);
				errors++;
				testBad = 1'b1;
			end
			finishTest(vectors[i].name);
		end

		@(negedge clk);
		checkIdle();
		finishTest("idle");

		$display("summary: %0d tests, %0d bad, %0d mismatches or errors",
			testCount, badTests, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule
